// File: design/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Register data width, one machine word
`define CSR_XLEN 32

// CSR address field of the instruction
`define CSR_ADDR_W 12

// Machine timer pending bit in mip
`define CSR_MTIP_BIT 7

`endif

// File: design/csr_map_pkg.sv
`include "csr_settings.svh"

package csr_map_pkg;

    // ============================================================
    // CSR addresses
    // ============================================================

    // Machine trap setup and handling
    localparam logic [`CSR_ADDR_W-1:0] csr_mstatus_addr   = 12'h300;
    localparam logic [`CSR_ADDR_W-1:0] csr_mie_addr       = 12'h304;
    localparam logic [`CSR_ADDR_W-1:0] csr_mtvec_addr     = 12'h305;
    localparam logic [`CSR_ADDR_W-1:0] csr_mscratch_addr  = 12'h340;
    localparam logic [`CSR_ADDR_W-1:0] csr_mepc_addr      = 12'h341;
    localparam logic [`CSR_ADDR_W-1:0] csr_mcause_addr    = 12'h342;
    localparam logic [`CSR_ADDR_W-1:0] csr_mtval_addr     = 12'h343;
    localparam logic [`CSR_ADDR_W-1:0] csr_mip_addr       = 12'h344;

    // Machine counters, writable
    localparam logic [`CSR_ADDR_W-1:0] csr_mcycle_addr    = 12'hB00;
    localparam logic [`CSR_ADDR_W-1:0] csr_minstret_addr  = 12'hB02;
    localparam logic [`CSR_ADDR_W-1:0] csr_mcycleh_addr   = 12'hB80;
    localparam logic [`CSR_ADDR_W-1:0] csr_minstreth_addr = 12'hB82;

    // User read-only shadows of the machine counters
    localparam logic [`CSR_ADDR_W-1:0] csr_cycle_addr     = 12'hC00;
    localparam logic [`CSR_ADDR_W-1:0] csr_instret_addr   = 12'hC02;
    localparam logic [`CSR_ADDR_W-1:0] csr_cycleh_addr    = 12'hC80;
    localparam logic [`CSR_ADDR_W-1:0] csr_instreth_addr  = 12'hC82;

    // Custom timer, in the machine custom read/write space
    localparam logic [`CSR_ADDR_W-1:0] csr_mtime_addr     = 12'hBC0;
    localparam logic [`CSR_ADDR_W-1:0] csr_mtimecmp_addr  = 12'hBC1;

    // ============================================================
    // mcause values
    // ============================================================
    localparam logic [`CSR_XLEN-1:0] cause_illegal_instruction = 32'h0000_0002;
    localparam logic [`CSR_XLEN-1:0] cause_breakpoint          = 32'h0000_0003;
    localparam logic [`CSR_XLEN-1:0] cause_misaligned_access   = 32'h0000_0004;
    localparam logic [`CSR_XLEN-1:0] cause_illegal_csr_access  = 32'h0000_000B;
    // Interrupt flag in the top bit
    localparam logic [`CSR_XLEN-1:0] cause_timer_interrupt     = 32'h8000_0007;

endpackage

// File: design/csr_types_pkg.sv
`include "csr_settings.svh"

package csr_types_pkg;

    typedef logic [`CSR_XLEN-1:0]   csr_data_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [1:0]             csr_op_t;

    // CSR operation encoding
    localparam csr_op_t csr_op_none  = 2'd0;
    localparam csr_op_t csr_op_write = 2'd1;
    localparam csr_op_t csr_op_set   = 2'd2;
    localparam csr_op_t csr_op_clear = 2'd3;

    // Decoded CSR instruction from the core
    typedef struct packed {
        logic      wren;
        logic      rden;
        csr_op_t   op;
        csr_addr_t addr;
        csr_data_t data_imm;
        logic      imm_sel;
    } csr_inst_t;

    // Single resolved write for this cycle
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t wdata;
    } csr_write_t;

    typedef struct packed {
        logic      illegal_instruction;
        logic      misaligned_access;
        logic      illegal_csr_access;
        logic      breakpoint;
        logic      timer_interrupt;
        logic      external_interrupt;
        logic      mret;
        csr_data_t pc;
        csr_data_t mtval;
    } csr_trap_req_t;

    typedef struct packed {
        logic      trap_jump_en;
        csr_data_t trap_jump_addr;
        logic      trap_return_en;
        csr_data_t trap_return_addr;
    } csr_pc_update_t;

    typedef struct packed {
        csr_data_t mstatus;
        csr_data_t mie;
        csr_data_t mtvec;
        csr_data_t mscratch;
        csr_data_t mepc;
        csr_data_t mcause;
        csr_data_t mtval;
        csr_data_t mip;
    } csr_trap_state_t;

    typedef struct packed {
        csr_data_t mcycle;
        csr_data_t mcycleh;
        csr_data_t minstret;
        csr_data_t minstreth;
    } csr_count_state_t;

    typedef struct packed {
        csr_data_t mtime;
        csr_data_t mtimecmp;
    } csr_timer_state_t;

    // Status toward the core for interrupt decisions
    typedef struct packed {
        csr_data_t mstatus;
        csr_data_t mie;
        csr_data_t mtime;
        csr_data_t mtimecmp;
    } csr_timer_status_t;

endpackage

// File: design/csr_access_unit.sv
`timescale 1ns/100ps

module csr_access_unit
    import csr_types_pkg::*, csr_map_pkg::*;
(
    input  csr_inst_t        inst,
    input  csr_data_t        reg_data,
    input  csr_trap_state_t  trap_state,
    input  csr_count_state_t count_state,
    input  csr_timer_state_t timer_state,
    output csr_data_t        read_data,
    output csr_write_t       csr_write
);

    csr_data_t cur_value;
    csr_data_t operand;
    csr_data_t new_value;

    // ============================================================
    // Read multiplexer
    // ============================================================
    always_comb begin
        case (inst.addr)
            csr_mstatus_addr:   cur_value = trap_state.mstatus;
            csr_mie_addr:       cur_value = trap_state.mie;
            csr_mtvec_addr:     cur_value = trap_state.mtvec;
            csr_mscratch_addr:  cur_value = trap_state.mscratch;
            csr_mepc_addr:      cur_value = trap_state.mepc;
            csr_mcause_addr:    cur_value = trap_state.mcause;
            csr_mtval_addr:     cur_value = trap_state.mtval;
            csr_mip_addr:       cur_value = trap_state.mip;
            // Machine counters and their user shadows share storage
            csr_mcycle_addr,
            csr_cycle_addr:     cur_value = count_state.mcycle;
            csr_mcycleh_addr,
            csr_cycleh_addr:    cur_value = count_state.mcycleh;
            csr_minstret_addr,
            csr_instret_addr:   cur_value = count_state.minstret;
            csr_minstreth_addr,
            csr_instreth_addr:  cur_value = count_state.minstreth;
            csr_mtime_addr:     cur_value = timer_state.mtime;
            csr_mtimecmp_addr:  cur_value = timer_state.mtimecmp;
            default:            cur_value = '0;
        endcase
    end

    assign read_data = inst.rden ? cur_value : '0;

    // ============================================================
    // Write value
    // ============================================================

    // Immediate form (csrrwi etc) or register source
    assign operand = inst.imm_sel ? inst.data_imm : reg_data;

    always_comb begin
        case (inst.op)
            csr_op_write: new_value = operand;
            csr_op_set:   new_value = cur_value | operand;
            csr_op_clear: new_value = cur_value & ~operand;
            default:      new_value = cur_value;
        endcase
    end

    // Units decode the address themselves and ignore what they do not own
    assign csr_write.en    = inst.wren && (inst.op != csr_op_none);
    assign csr_write.addr  = inst.addr;
    assign csr_write.wdata = new_value;

endmodule

// File: design/csr_trap_regs.sv
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_trap_regs
    import csr_types_pkg::*, csr_map_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  csr_write_t      csr_write,
    input  csr_trap_req_t   trap_req,
    input  logic            timer_match,
    output csr_trap_state_t trap_state,
    output csr_pc_update_t  pc_update
);

    localparam csr_data_t mtip_mask = csr_data_t'(1) << `CSR_MTIP_BIT;

    csr_trap_state_t regs;
    logic            sync_trap;
    csr_data_t       sync_cause;

    // ============================================================
    // Synchronous exception select
    // ============================================================

    // Later checks win, so breakpoint has the highest priority here
    always_comb begin
        sync_trap  = 1'b0;
        sync_cause = '0;
        if (trap_req.illegal_instruction) begin
            sync_trap  = 1'b1;
            sync_cause = cause_illegal_instruction;
        end
        if (trap_req.misaligned_access) begin
            sync_trap  = 1'b1;
            sync_cause = cause_misaligned_access;
        end
        if (trap_req.illegal_csr_access) begin
            sync_trap  = 1'b1;
            sync_cause = cause_illegal_csr_access;
        end
        if (trap_req.breakpoint) begin
            sync_trap  = 1'b1;
            sync_cause = cause_breakpoint;
        end
    end

    // ============================================================
    // Register update
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '0;
        end else begin
            // Software access first, hardware updates below take precedence
            if (csr_write.en) begin
                case (csr_write.addr)
                    csr_mstatus_addr:  regs.mstatus  <= csr_write.wdata;
                    csr_mie_addr:      regs.mie      <= csr_write.wdata;
                    csr_mtvec_addr:    regs.mtvec    <= csr_write.wdata;
                    csr_mscratch_addr: regs.mscratch <= csr_write.wdata;
                    csr_mepc_addr:     regs.mepc     <= csr_write.wdata;
                    csr_mcause_addr:   regs.mcause   <= csr_write.wdata;
                    csr_mtval_addr:    regs.mtval    <= csr_write.wdata;
                    csr_mip_addr:      regs.mip      <= csr_write.wdata;
                    default:           ;
                endcase
            end
            if (sync_trap) begin
                regs.mcause <= sync_cause;
                regs.mepc   <= trap_req.pc;
                regs.mtval  <= trap_req.mtval;
            end
            // Timer interrupt keeps whatever mtval already holds
            if (trap_req.timer_interrupt) begin
                regs.mcause <= cause_timer_interrupt;
                regs.mepc   <= trap_req.pc;
            end
            if (timer_match) begin
                regs.mip <= mtip_mask;
            end
        end
    end

    assign trap_state = regs;

    // ============================================================
    // PC redirect
    // ============================================================

    // External interrupt redirects but records no cause
    assign pc_update.trap_jump_en     = trap_req.illegal_instruction
                                      | trap_req.misaligned_access
                                      | trap_req.illegal_csr_access
                                      | trap_req.breakpoint
                                      | trap_req.timer_interrupt
                                      | trap_req.external_interrupt;
    assign pc_update.trap_jump_addr   = regs.mtvec;
    assign pc_update.trap_return_en   = trap_req.mret;
    assign pc_update.trap_return_addr = regs.mepc;

endmodule

// File: design/csr_counters.sv
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_counters
    import csr_types_pkg::*, csr_map_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  csr_write_t       csr_write,
    input  logic             valid_inst,
    output csr_count_state_t count_state
);

    csr_count_state_t cnt;

    // Full 64-bit increments, carry lands in the high word
    logic [2*`CSR_XLEN-1:0] cycle_inc;
    logic [2*`CSR_XLEN-1:0] instret_inc;

    assign cycle_inc   = {cnt.mcycleh, cnt.mcycle} + 1'b1;
    assign instret_inc = {cnt.minstreth, cnt.minstret} + 1'b1;

    // Cycle counter, steps every clock
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt.mcycle  <= '0;
            cnt.mcycleh <= '0;
        end else if (csr_write.en && (csr_write.addr == csr_mcycle_addr)) begin
            cnt.mcycle <= csr_write.wdata;
        end else if (csr_write.en && (csr_write.addr == csr_mcycleh_addr)) begin
            cnt.mcycleh <= csr_write.wdata;
        end else begin
            {cnt.mcycleh, cnt.mcycle} <= cycle_inc;
        end
    end

    // Retired instruction counter
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt.minstret  <= '0;
            cnt.minstreth <= '0;
        end else if (csr_write.en && (csr_write.addr == csr_minstret_addr)) begin
            cnt.minstret <= csr_write.wdata;
        end else if (csr_write.en && (csr_write.addr == csr_minstreth_addr)) begin
            cnt.minstreth <= csr_write.wdata;
        end else if (valid_inst) begin
            {cnt.minstreth, cnt.minstret} <= instret_inc;
        end
    end

    assign count_state = cnt;

endmodule

// File: design/csr_timer.sv
`timescale 1ns/100ps

module csr_timer
    import csr_types_pkg::*, csr_map_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  csr_write_t       csr_write,
    output csr_timer_state_t timer_state,
    output logic             timer_match
);

    csr_data_t mtime;
    csr_data_t mtimecmp;

    // Free running, no software write path
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp <= '0;
        end else if (csr_write.en && (csr_write.addr == csr_mtimecmp_addr)) begin
            mtimecmp <= csr_write.wdata;
        end
    end

    // Zero compare value means the timer is disarmed
    assign timer_match = (mtime == mtimecmp) && (mtime != '0) && (mtimecmp != '0);

    assign timer_state.mtime    = mtime;
    assign timer_state.mtimecmp = mtimecmp;

endmodule

// File: design/csr_file.sv
`timescale 1ns/100ps

module csr_file
    import csr_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  csr_inst_t         inst,
    input  csr_data_t         reg_data,
    input  csr_trap_req_t     trap_req,
    input  logic              valid_inst,
    output csr_data_t         read_data,
    output csr_pc_update_t    pc_update,
    output csr_timer_status_t timer_status
);

    csr_write_t       csr_write;
    csr_trap_state_t  trap_state;
    csr_count_state_t count_state;
    csr_timer_state_t timer_state;
    logic             timer_match;

    csr_access_unit csr_access_unit_i (
        .inst        (inst),
        .reg_data    (reg_data),
        .trap_state  (trap_state),
        .count_state (count_state),
        .timer_state (timer_state),
        .read_data   (read_data),
        .csr_write   (csr_write)
    );

    csr_trap_regs csr_trap_regs_i (
        .clk         (clk),
        .rst         (rst),
        .csr_write   (csr_write),
        .trap_req    (trap_req),
        .timer_match (timer_match),
        .trap_state  (trap_state),
        .pc_update   (pc_update)
    );

    csr_counters csr_counters_i (
        .clk         (clk),
        .rst         (rst),
        .csr_write   (csr_write),
        .valid_inst  (valid_inst),
        .count_state (count_state)
    );

    csr_timer csr_timer_i (
        .clk         (clk),
        .rst         (rst),
        .csr_write   (csr_write),
        .timer_state (timer_state),
        .timer_match (timer_match)
    );

    // Status bundle toward the core
    assign timer_status.mstatus  = trap_state.mstatus;
    assign timer_status.mie      = trap_state.mie;
    assign timer_status.mtime    = timer_state.mtime;
    assign timer_status.mtimecmp = timer_state.mtimecmp;

endmodule

// File: tb/csr_file_assert.sv
`timescale 1ns/100ps

module csr_file_assert
    import csr_types_pkg::*;
(
    input logic           clk,
    input logic           rst,
    input csr_inst_t      inst,
    input csr_trap_req_t  trap_req,
    input csr_pc_update_t pc_update,
    input csr_data_t      read_data
);

    logic any_trap;

    assign any_trap = trap_req.illegal_instruction | trap_req.misaligned_access
                    | trap_req.illegal_csr_access | trap_req.breakpoint
                    | trap_req.timer_interrupt | trap_req.external_interrupt;

    // ============================================================
    // Redirect and read path
    // ============================================================
    jump_en_follows_flags: assert property (@(posedge clk) disable iff (rst)
        pc_update.trap_jump_en == any_trap)
        else $error("trap_jump_en does not match the OR of the trap flags");

    return_en_follows_mret: assert property (@(posedge clk) disable iff (rst)
        pc_update.trap_return_en == trap_req.mret)
        else $error("trap_return_en does not match mret");

    read_zero_without_rden: assert property (@(posedge clk) disable iff (rst)
        !inst.rden |-> (read_data == '0))
        else $error("read_data is nonzero while rden is low");

endmodule

bind csr_file csr_file_assert csr_file_assert_i (
    .clk       (clk),
    .rst       (rst),
    .inst      (inst),
    .trap_req  (trap_req),
    .pc_update (pc_update),
    .read_data (read_data)
);

// File: tb/csr_file_tb.sv
`timescale 1ns/100ps

module csr_file_tb
    import csr_types_pkg::*, csr_map_pkg::*;
();

    localparam int len_rw      = 200;
    localparam int len_trap    = 200;
    localparam int len_count   = 150;
    localparam int len_timer   = 40;
    localparam int len_zero    = 80;
    localparam int cycle_limit = 2 * (3 + len_rw + len_trap + 2 * len_count + len_timer + len_zero);
    // Only the timer pending bit survives a match
    localparam csr_data_t mtip_value = 32'h0000_0080;

    logic              clk = 1'b0;
    logic              rst;
    csr_inst_t         inst;
    csr_data_t         reg_data;
    csr_trap_req_t     trap_req;
    logic              valid_inst;
    csr_data_t         read_data;
    csr_pc_update_t    pc_update;
    csr_timer_status_t timer_status;

    // Register model
    csr_trap_state_t   m_trap;
    csr_count_state_t  m_cnt;
    csr_timer_state_t  m_tmr;

    logic [31:0] lfsr = 32'h3d84;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    string       test_name = "reset";

    csr_addr_t rw_addrs[4]    = '{csr_mscratch_addr, csr_mtvec_addr, csr_mie_addr,
                                  csr_mstatus_addr};
    csr_addr_t trap_addrs[8]  = '{csr_mstatus_addr, csr_mie_addr, csr_mtvec_addr,
                                  csr_mscratch_addr, csr_mepc_addr, csr_mcause_addr,
                                  csr_mtval_addr, csr_mip_addr};
    csr_addr_t cycle_addrs[4] = '{csr_mcycle_addr, csr_mcycleh_addr, csr_cycle_addr,
                                  csr_cycleh_addr};
    csr_addr_t inst_addrs[4]  = '{csr_minstret_addr, csr_minstreth_addr, csr_instret_addr,
                                  csr_instreth_addr};
    // misa, delegation, counter enables, ID registers and an hpm counter
    csr_addr_t zero_addrs[8]  = '{12'h301, 12'h302, 12'h303, 12'h306, 12'h320, 12'hF11,
                                  12'hF14, 12'hB03};

    csr_file csr_file_i (
        .clk          (clk),
        .rst          (rst),
        .inst         (inst),
        .reg_data     (reg_data),
        .trap_req     (trap_req),
        .valid_inst   (valid_inst),
        .read_data    (read_data),
        .pc_update    (pc_update),
        .timer_status (timer_status)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    // ============================================================
    // Model
    // ============================================================
    function automatic csr_data_t model_value(input csr_addr_t addr);
        case (addr)
            csr_mstatus_addr:                     return m_trap.mstatus;
            csr_mie_addr:                         return m_trap.mie;
            csr_mtvec_addr:                       return m_trap.mtvec;
            csr_mscratch_addr:                    return m_trap.mscratch;
            csr_mepc_addr:                        return m_trap.mepc;
            csr_mcause_addr:                      return m_trap.mcause;
            csr_mtval_addr:                       return m_trap.mtval;
            csr_mip_addr:                         return m_trap.mip;
            csr_mcycle_addr, csr_cycle_addr:      return m_cnt.mcycle;
            csr_mcycleh_addr, csr_cycleh_addr:    return m_cnt.mcycleh;
            csr_minstret_addr, csr_instret_addr:  return m_cnt.minstret;
            csr_minstreth_addr, csr_instreth_addr: return m_cnt.minstreth;
            csr_mtime_addr:                       return m_tmr.mtime;
            csr_mtimecmp_addr:                    return m_tmr.mtimecmp;
            default:                              return '0;
        endcase
    endfunction

    task automatic update_model();
        csr_data_t cur;
        csr_data_t opnd;
        csr_data_t nv;
        logic      wen;
        logic      match;
        logic      sync;
        csr_data_t cause;
        cur   = model_value(inst.addr);
        opnd  = inst.imm_sel ? inst.data_imm : reg_data;
        nv    = (inst.op == 2'd1) ? opnd : (inst.op == 2'd2) ? (cur | opnd) : (cur & ~opnd);
        wen   = inst.wren && (inst.op != 2'd0);
        match = (m_tmr.mtime == m_tmr.mtimecmp) && (m_tmr.mtime != '0);
        if (wen) begin
            case (inst.addr)
                csr_mstatus_addr:  m_trap.mstatus = nv;
                csr_mie_addr:      m_trap.mie = nv;
                csr_mtvec_addr:    m_trap.mtvec = nv;
                csr_mscratch_addr: m_trap.mscratch = nv;
                csr_mepc_addr:     m_trap.mepc = nv;
                csr_mcause_addr:   m_trap.mcause = nv;
                csr_mtval_addr:    m_trap.mtval = nv;
                csr_mip_addr:      m_trap.mip = nv;
                csr_mtimecmp_addr: m_tmr.mtimecmp = nv;
                default:           ;
            endcase
        end
        // Last requested cause wins
        sync  = 1'b0;
        cause = '0;
        if (trap_req.illegal_instruction) {sync, cause} = {1'b1, 32'd2};
        if (trap_req.misaligned_access) {sync, cause} = {1'b1, 32'd4};
        if (trap_req.illegal_csr_access) {sync, cause} = {1'b1, 32'd11};
        if (trap_req.breakpoint) {sync, cause} = {1'b1, 32'd3};
        if (sync) begin
            m_trap.mcause = cause;
            m_trap.mepc   = trap_req.pc;
            m_trap.mtval  = trap_req.mtval;
        end
        if (trap_req.timer_interrupt) begin
            m_trap.mcause = 32'h8000_0007;
            m_trap.mepc   = trap_req.pc;
        end
        if (match) m_trap.mip = mtip_value;
        // A counter write replaces the step, the other word holds
        if (wen && inst.addr == csr_mcycle_addr) begin
            m_cnt.mcycle = nv;
        end else if (wen && inst.addr == csr_mcycleh_addr) begin
            m_cnt.mcycleh = nv;
        end else begin
            {m_cnt.mcycleh, m_cnt.mcycle} = {m_cnt.mcycleh, m_cnt.mcycle} + 64'd1;
        end
        if (wen && inst.addr == csr_minstret_addr) begin
            m_cnt.minstret = nv;
        end else if (wen && inst.addr == csr_minstreth_addr) begin
            m_cnt.minstreth = nv;
        end else if (valid_inst) begin
            {m_cnt.minstreth, m_cnt.minstret} = {m_cnt.minstreth, m_cnt.minstret} + 64'd1;
        end
        m_tmr.mtime = m_tmr.mtime + 32'd1;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            m_trap = '0;
            m_cnt  = '0;
            m_tmr  = '0;
        end else begin
            update_model();
        end
    end

    // ============================================================
    // Checks and stimulus
    // ============================================================
    task automatic check_value(input string what, input csr_data_t expected,
                               input csr_data_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        check_value("read_data", inst.rden ? model_value(inst.addr) : '0, read_data);
        check_value("trap_jump_en", csr_data_t'(trap_req.illegal_instruction
            | trap_req.misaligned_access | trap_req.illegal_csr_access | trap_req.breakpoint
            | trap_req.timer_interrupt | trap_req.external_interrupt),
            csr_data_t'(pc_update.trap_jump_en));
        check_value("trap_jump_addr", m_trap.mtvec, pc_update.trap_jump_addr);
        check_value("trap_return_en", csr_data_t'(trap_req.mret),
            csr_data_t'(pc_update.trap_return_en));
        check_value("trap_return_addr", m_trap.mepc, pc_update.trap_return_addr);
        check_value("status_mstatus", m_trap.mstatus, timer_status.mstatus);
        check_value("status_mie", m_trap.mie, timer_status.mie);
        check_value("status_mtime", m_tmr.mtime, timer_status.mtime);
        check_value("status_mtimecmp", m_tmr.mtimecmp, timer_status.mtimecmp);
    endtask

    task automatic random_inst(input csr_addr_t addr);
        inst.wren     = rand_bits(2) != 0;
        inst.rden     = 1'b1;
        inst.op       = rand_bits(2);
        inst.addr     = addr;
        inst.data_imm = rand_bits(32);
        inst.imm_sel  = rand_bits(1);
        reg_data      = rand_bits(32);
        valid_inst    = rand_bits(1);
    endtask

    task automatic access_csr(input csr_addr_t addr, input logic wr, input csr_data_t value);
        next_cycle();
        inst      = '0;
        inst.rden = 1'b1;
        inst.wren = wr;
        inst.op   = wr ? 2'd1 : 2'd0;
        inst.addr = addr;
        reg_data  = value;
    endtask

    initial begin
        rst        = 1'b1;
        inst       = '0;
        reg_data   = '0;
        trap_req   = '0;
        valid_inst = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        test_name = "rw_trap_csrs";
        repeat (len_rw) begin
            next_cycle();
            random_inst(rw_addrs[rand_bits(2)]);
        end

        // Mostly reads, with some writes racing the trap capture
        test_name = "trap_capture";
        repeat (len_trap) begin
            next_cycle();
            random_inst(trap_addrs[rand_bits(3)]);
            inst.wren = rand_bits(3) == 0;
            trap_req.illegal_instruction = rand_bits(2) == 0;
            trap_req.misaligned_access   = rand_bits(2) == 0;
            trap_req.illegal_csr_access  = rand_bits(2) == 0;
            trap_req.breakpoint          = rand_bits(2) == 0;
            trap_req.timer_interrupt     = rand_bits(2) == 0;
            trap_req.external_interrupt  = rand_bits(2) == 0;
            trap_req.mret                = rand_bits(2) == 0;
            trap_req.pc                  = rand_bits(32);
            trap_req.mtval               = rand_bits(32);
        end
        trap_req = '0;

        // All ones in mcycle carries into mcycleh
        test_name = "cycle_counter";
        access_csr(csr_mcycle_addr, 1'b1, 32'hFFFF_FFFF);
        repeat (3) access_csr(csr_cycleh_addr, 1'b0, '0);
        repeat (len_count - 4) begin
            next_cycle();
            random_inst(cycle_addrs[rand_bits(2)]);
            inst.wren = rand_bits(4) == 0;
        end

        test_name = "instret_counter";
        repeat (len_count) begin
            next_cycle();
            random_inst(inst_addrs[rand_bits(2)]);
            inst.wren = rand_bits(4) == 0;
        end
        valid_inst = 1'b0;

        test_name = "timer_match";
        access_csr(csr_mtime_addr, 1'b0, '0);
        access_csr(csr_mtimecmp_addr, 1'b1, m_tmr.mtime + 32'd12);
        repeat (len_timer - 3) begin
            access_csr(rand_bits(1) ? csr_mtime_addr : csr_mip_addr, 1'b0, '0);
        end
        access_csr(csr_mip_addr, 1'b0, '0);
        next_cycle();
        check_value("mip_after_match", mtip_value, read_data);

        test_name = "unknown_addr";
        repeat (len_zero) begin
            next_cycle();
            random_inst(zero_addrs[rand_bits(3)]);
            if (rand_bits(1)) begin
                inst.addr = rw_addrs[rand_bits(2)];
                inst.rden = 1'b0;
                inst.wren = 1'b0;
            end
        end
        next_cycle();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+design
design/csr_map_pkg.sv
design/csr_types_pkg.sv
design/csr_access_unit.sv
design/csr_trap_regs.sv
design/csr_counters.sv
design/csr_timer.sv
design/csr_file.sv
tb/csr_file_assert.sv
tb/csr_file_tb.sv

// File: run.sh
#!/bin/sh
# Build the CSR file testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module csr_file_tb \
    -f sim.f -o csr_sim || exit 1
out=$(./obj_dir/csr_sim)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
